// File: files.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/op_decode.sv
verilog/alu.sv
verilog/pc_unit.sv
verilog/cpu_ctrl.sv
verilog/cpu_top.sv
sim/tb_checker.sv
sim/tb_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_top.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_top;
    import cpu_pkg::*;

    localparam int N_INSTR = 300;
    localparam int RUN_LIMIT = 100000;

    logic    clk;
    logic    rst;
    byte_t   bus_dat;
    logic    bus_ack;
    wb_req_t bus_req;
    logic    sync;
    logic    jam;
    logic    done;
    int      value_errs;
    int      proto_errs;
    int      other_errs;

    byte_t       mem [0:65535];
    logic [31:0] lfsr;
    logic [1:0]  wait_left;
    addr_t       start [0:N_INSTR];

    byte_t legal_ops [0:41] = '{
        8'h09, 8'h29, 8'h49, 8'h69, 8'hc9, 8'he9,
        8'h05, 8'h25, 8'h45, 8'h65, 8'hc5, 8'he5,
        8'ha9, 8'ha2, 8'ha0, 8'ha5, 8'ha6, 8'ha4,
        8'h85, 8'h86, 8'h84, 8'haa, 8'h8a, 8'ha8, 8'h98,
        8'he8, 8'hc8, 8'hca, 8'h88, 8'h18, 8'h38, 8'hb8, 8'hea,
        8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hb0, 8'hd0, 8'hf0, 8'h4c
    };

    // galois lfsr, one step per bit taken
    function logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic int op_length(input byte_t op);
        if (op == 8'h4c) begin
            return 3;
        end
        if (op inside {8'haa, 8'h8a, 8'ha8, 8'h98, 8'he8, 8'hc8, 8'hca, 8'h88,
                       8'h18, 8'h38, 8'hb8, 8'hea}) begin
            return 1;
        end
        return 2;
    endfunction

    // forward targets only, so the program always reaches the jam opcode
    task automatic build_program();
        addr_t       p;
        byte_t       op;
        logic [31:0] r;
        int          j;
        addr_t       off;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ 8'h5a;
        end
        for (int i = 0; i < 256; i++) begin
            r = take_bits(8);
            mem[i] = r[7:0];
        end
        mem[`CPU_RST_VECTOR] = 8'h00;
        mem[`CPU_RST_VECTOR + 16'd1] = 8'h02;
        p = 16'h0200;
        for (int i = 0; i < N_INSTR; i++) begin
            r = take_bits(6);
            op = legal_ops[r % 42];
            start[i] = p;
            mem[p] = op;
            r = take_bits(8);
            mem[p + 16'd1] = r[7:0];
            r = take_bits(8);
            mem[p + 16'd2] = r[7:0];
            p = p + 16'(op_length(op));
        end
        start[N_INSTR] = p;
        mem[p] = 8'h02;
        for (int i = 0; i < N_INSTR; i++) begin
            op = mem[start[i]];
            r = take_bits(5);
            j = i + 1 + int'(r % 20);
            if (j > N_INSTR) begin
                j = N_INSTR;
            end
            if (op == 8'h4c) begin
                mem[start[i] + 16'd1] = start[j][7:0];
                mem[start[i] + 16'd2] = start[j][15:8];
            end else if (op[4:0] == 5'h10) begin
                off = start[j] - start[i] - 16'd2;
                mem[start[i] + 16'd1] = off[7:0];
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // memory slave with 0 to 3 wait cycles per transfer
    always @(posedge clk) begin
        logic [31:0] r;
        if (rst) begin
            bus_ack <= 1'b0;
            wait_left <= 2'd0;
        end else if (bus_ack) begin
            bus_ack <= 1'b0;
        end else if (bus_req.stb) begin
            if (wait_left == 2'd0) begin
                bus_ack <= 1'b1;
                if (bus_req.we) begin
                    mem[bus_req.adr] <= bus_req.dat;
                end else begin
                    bus_dat <= mem[bus_req.adr];
                end
                r = take_bits(2);
                wait_left <= r[1:0];
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    cpu_top UUT (
        .clk     (clk),
        .rst     (rst),
        .bus_dat (bus_dat),
        .bus_ack (bus_ack),
        .bus_req (bus_req),
        .sync    (sync),
        .jam     (jam)
    );

    tb_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .bus_req    (bus_req),
        .bus_dat    (bus_dat),
        .bus_ack    (bus_ack),
        .sync       (sync),
        .jam        (jam),
        .done       (done),
        .value_errs (value_errs),
        .proto_errs (proto_errs),
        .other_errs (other_errs)
    );

    initial begin
        int n;
        rst = 1'b1;
        bus_ack = 1'b0;
        bus_dat = 8'h00;
        lfsr = 32'h2f24d558;
        build_program();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        n = 0;
        while (!done && n < RUN_LIMIT) begin
            n++;
            @(posedge clk);
        end
        if (!done) begin
            $display("run did not finish within %0d cycles", RUN_LIMIT);
        end
        $display("errors: value %0d, protocol %0d, other %0d",
                 value_errs, proto_errs, other_errs);
        if (done && value_errs == 0 && proto_errs == 0 && other_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: sim/tb_checker.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_checker
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t bus_req,
    input  byte_t   bus_dat,
    input  logic    bus_ack,
    input  logic    sync,
    input  logic    jam,
    output logic    done,
    output int      value_errs,
    output int      proto_errs,
    output int      other_errs
);

    localparam int WAIT_LIMIT = 200;
    localparam int QUIET_CYCLES = 50;

    // model state
    byte_t   a;
    byte_t   x;
    byte_t   y;
    flags_t  f;
    addr_t   pc;
    logic    stop;
    wb_req_t prev_req;
    logic    prev_ack;

    task automatic compare(input string name, input logic [15:0] exp, input logic [15:0] got);
        if (exp !== got) begin
            value_errs++;
            $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // wait for the next completed transfer and check its fields
    task automatic xfer(input addr_t adr, input logic we, input byte_t dat,
                        input logic sync_exp, output byte_t rd);
        int n;
        n = 0;
        rd = '0;
        @(negedge clk);
        while (!(bus_req.stb && bus_ack) && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (n >= WAIT_LIMIT) begin
            other_errs++;
            $display("no transfer completed within %0d cycles, expected one at %h",
                     WAIT_LIMIT, adr);
            stop = 1'b1;
        end else begin
            compare("adr", adr, bus_req.adr);
            compare("we", {15'd0, we}, {15'd0, bus_req.we});
            compare("sync", {15'd0, sync_exp}, {15'd0, sync});
            if (we) begin
                compare("dat", {8'd0, dat}, {8'd0, bus_req.dat});
            end
            rd = bus_dat;
        end
    endtask

    function automatic void set_nz(input byte_t r);
        f.n = r[7];
        f.z = (r == 8'd0);
    endfunction

    task automatic add(input byte_t b);
        logic [8:0] s;
        s = {1'b0, a} + {1'b0, b} + {8'd0, f.c};
        f.v = ~(a[7] ^ b[7]) & (a[7] ^ s[7]);
        f.c = s[8];
        a = s[7:0];
        set_nz(a);
    endtask

    // group one operation chosen by the top three opcode bits
    task automatic alu_model(input logic [2:0] sel, input byte_t b);
        logic [8:0] s;
        case (sel)
            3'd0: a = a | b;
            3'd1: a = a & b;
            3'd2: a = a ^ b;
            3'd3: add(b);
            3'd6: begin
                s = {1'b0, a} + {1'b0, ~b} + 9'd1;
                f.c = s[8];
            end
            default: add(~b);
        endcase
        if (sel == 3'd6) begin
            set_nz(s[7:0]);
        end else begin
            set_nz(a);
        end
    endtask

    // bpl bmi bvc bvs bcc bcs bne beq
    function automatic logic branch_taken(input byte_t op);
        logic taken;
        case (op)
            8'h10:   taken = !f.n;
            8'h30:   taken = f.n;
            8'h50:   taken = !f.v;
            8'h70:   taken = f.v;
            8'h90:   taken = !f.c;
            8'hb0:   taken = f.c;
            8'hd0:   taken = !f.z;
            default: taken = f.z;
        endcase
        return taken;
    endfunction

    // single byte instructions
    task automatic apply_implied(input byte_t op);
        case (op)
            8'haa:   x = a;
            8'h8a:   a = x;
            8'ha8:   y = a;
            8'h98:   a = y;
            8'he8:   x = x + 8'd1;
            8'hc8:   y = y + 8'd1;
            8'hca:   x = x - 8'd1;
            8'h88:   y = y - 8'd1;
            8'h18:   f.c = 1'b0;
            8'h38:   f.c = 1'b1;
            8'hb8:   f.v = 1'b0;
            default: ;
        endcase
        case (op)
            8'haa, 8'he8, 8'hca: set_nz(x);
            8'h8a, 8'h98:        set_nz(a);
            8'ha8, 8'hc8, 8'h88: set_nz(y);
            default: ;
        endcase
    endtask

    task automatic wait_jam();
        int n;
        n = 0;
        while (!jam && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (!jam) begin
            other_errs++;
            $display("jam did not rise after the illegal opcode");
        end
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            if (bus_req.stb || bus_req.cyc) begin
                other_errs++;
                $display("a transfer started after jam at %0t", $time);
                break;
            end
        end
    endtask

    task automatic run_instruction();
        byte_t op;
        byte_t v;
        byte_t z;
        byte_t hi;
        xfer(pc, 1'b0, 8'd0, 1'b1, op);
        if (stop) begin
            return;
        end
        case (op)
            8'h09, 8'h29, 8'h49, 8'h69, 8'hc9, 8'he9: begin
                xfer(pc + 16'd1, 1'b0, 8'd0, 1'b0, v);
                pc = pc + 16'd2;
                alu_model(op[7:5], v);
            end
            8'h05, 8'h25, 8'h45, 8'h65, 8'hc5, 8'he5: begin
                xfer(pc + 16'd1, 1'b0, 8'd0, 1'b0, z);
                xfer({8'h00, z}, 1'b0, 8'd0, 1'b0, v);
                pc = pc + 16'd2;
                alu_model(op[7:5], v);
            end
            8'ha9, 8'ha2, 8'ha0, 8'ha5, 8'ha6, 8'ha4: begin
                xfer(pc + 16'd1, 1'b0, 8'd0, 1'b0, v);
                if (op[2]) begin
                    xfer({8'h00, v}, 1'b0, 8'd0, 1'b0, v);
                end
                pc = pc + 16'd2;
                case (op[1:0])
                    2'b01: a = v;
                    2'b10: x = v;
                    default: y = v;
                endcase
                set_nz(v);
            end
            8'h85, 8'h86, 8'h84: begin
                xfer(pc + 16'd1, 1'b0, 8'd0, 1'b0, z);
                case (op[1:0])
                    2'b01: v = a;
                    2'b10: v = x;
                    default: v = y;
                endcase
                xfer({8'h00, z}, 1'b1, v, 1'b0, hi);
                pc = pc + 16'd2;
            end
            8'haa, 8'h8a, 8'ha8, 8'h98, 8'he8, 8'hc8, 8'hca, 8'h88,
            8'h18, 8'h38, 8'hb8, 8'hea: begin
                apply_implied(op);
                pc = pc + 16'd1;
            end
            8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hb0, 8'hd0, 8'hf0: begin
                xfer(pc + 16'd1, 1'b0, 8'd0, 1'b0, v);
                if (branch_taken(op)) begin
                    pc = pc + 16'd2 + {{8{v[7]}}, v};
                end else begin
                    pc = pc + 16'd2;
                end
            end
            8'h4c: begin
                xfer(pc + 16'd1, 1'b0, 8'd0, 1'b0, v);
                xfer(pc + 16'd2, 1'b0, 8'd0, 1'b0, hi);
                pc = {hi, v};
            end
            8'h02: begin
                wait_jam();
                stop = 1'b1;
            end
            default: begin
                other_errs++;
                $display("fetched opcode %h that the program never holds", op);
                stop = 1'b1;
            end
        endcase
    endtask

    initial begin
        byte_t lo;
        byte_t hi;
        int    n;
        done = 1'b0;
        value_errs = 0;
        proto_errs = 0;
        other_errs = 0;
        stop = 1'b0;
        a = '0;
        x = '0;
        y = '0;
        f = '0;
        n = 0;
        @(negedge clk);
        while (rst && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (rst) begin
            other_errs++;
            $display("reset still high after %0d cycles", WAIT_LIMIT);
            stop = 1'b1;
        end else if (bus_req.cyc || bus_req.stb || sync || jam) begin
            other_errs++;
            $display("bus outputs not idle right after reset");
        end
        if (!stop) begin
            xfer(`CPU_RST_VECTOR, 1'b0, 8'd0, 1'b0, lo);
        end
        if (!stop) begin
            xfer(`CPU_RST_VECTOR + 16'd1, 1'b0, 8'd0, 1'b0, hi);
        end
        pc = {hi, lo};
        while (!stop) begin
            run_instruction();
        end
        done = 1'b1;
    end

    // handshake rules checked every cycle
    always @(negedge clk) begin
        if (rst) begin
            prev_req <= '0;
            prev_ack <= 1'b0;
        end else begin
            if (bus_req.stb && !bus_req.cyc) begin
                proto_errs++;
                $display("stb high without cyc at %0t", $time);
            end
            if (bus_ack && !bus_req.stb) begin
                proto_errs++;
                $display("ack seen without stb at %0t", $time);
            end
            if (prev_req.stb && !prev_ack && bus_req !== prev_req) begin
                proto_errs++;
                $display("request changed before ack at %0t", $time);
            end
            if (prev_ack && bus_req.stb) begin
                proto_errs++;
                $display("no idle cycle after ack at %0t", $time);
            end
            prev_req <= bus_req;
            prev_ack <= bus_ack;
        end
    end

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  byte_t   bus_dat,
    input  logic    bus_ack,
    output wb_req_t bus_req,
    output logic    sync,
    output logic    jam
);

    alu_in_t  alu_in;
    alu_out_t alu_out;
    pc_cmd_t  pc_cmd;
    addr_t    pc;
    byte_t    oa;

    cpu_ctrl u_ctrl (
        .clk     (clk),
        .rst     (rst),
        .bus_dat (bus_dat),
        .bus_ack (bus_ack),
        .alu_out (alu_out),
        .pc      (pc),
        .oa      (oa),
        .bus_req (bus_req),
        .sync    (sync),
        .jam     (jam),
        .alu_in  (alu_in),
        .pc_cmd  (pc_cmd)
    );

    alu u_alu (
        .alu_in  (alu_in),
        .alu_out (alu_out)
    );

    pc_unit u_pc (
        .clk    (clk),
        .rst    (rst),
        .pc_cmd (pc_cmd),
        .pc     (pc),
        .oa     (oa)
    );

endmodule

// File: verilog/cpu_ctrl.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_ctrl
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  byte_t    bus_dat,
    input  logic     bus_ack,
    input  alu_out_t alu_out,
    input  addr_t    pc,
    input  byte_t    oa,
    output wb_req_t  bus_req,
    output logic     sync,
    output logic     jam,
    output alu_in_t  alu_in,
    output pc_cmd_t  pc_cmd
);

    typedef enum logic [2:0] {
        S_VEC_LO,
        S_VEC_HI,
        S_FETCH,
        S_OPER,
        S_OPER_HI,
        S_MEM,
        S_GAP,
        S_JAM
    } step_e;

    step_e    step;
    step_e    resume;
    step_e    next_step;
    byte_t    ir;
    byte_t    a_reg;
    byte_t    x_reg;
    byte_t    y_reg;
    flags_t   p;
    byte_t    opcode;
    decoded_t dec;
    byte_t    src_val;
    logic     xfer_done;
    logic     final_ack;
    logic     br_flag;
    logic     br_taken;
    logic     is_alu;
    logic     upd_nz;
    logic     wr_dst;

    // during the fetch the opcode is still on the bus
    assign opcode = (step == S_FETCH) ? bus_dat : ir;

    op_decode u_decode (
        .opcode (opcode),
        .dec    (dec)
    );

    always_comb begin
        case (dec.src_reg)
            REG_X:   src_val = x_reg;
            REG_Y:   src_val = y_reg;
            default: src_val = a_reg;
        endcase
        case (dec.br_flag)
            2'd0:    br_flag = p.n;
            2'd1:    br_flag = p.v;
            2'd2:    br_flag = p.c;
            default: br_flag = p.z;
        endcase
    end

    assign br_taken = (br_flag == dec.br_sense);
    assign is_alu   = dec.op_class inside {OP_IMM_ALU, OP_ZPG_ALU};
    assign upd_nz   = is_alu || (dec.op_class inside {OP_IMM_LOAD, OP_ZPG_LOAD,
                                                      OP_TRANSFER, OP_INCDEC});
    assign wr_dst   = upd_nz && (dec.alu_op != ALU_CMP);

    assign alu_in.op = dec.alu_op;
    assign alu_in.a  = src_val;
    assign alu_in.b  = (dec.op_class == OP_TRANSFER) ? src_val : bus_dat;
    assign alu_in.ci = p.c;

    // wishbone request with one transfer per step
    always_comb begin
        bus_req = '0;
        sync    = 1'b0;
        case (step)
            S_VEC_LO:  bus_req.adr = `CPU_RST_VECTOR;
            S_VEC_HI:  bus_req.adr = `CPU_RST_VECTOR + 16'd1;
            S_FETCH: begin
                bus_req.adr = pc;
                sync        = 1'b1;
            end
            S_MEM: begin
                bus_req.adr = {8'h00, oa};
                bus_req.we  = (dec.op_class == OP_ZPG_STORE);
                bus_req.dat = src_val;
            end
            default:   bus_req.adr = pc;
        endcase
        bus_req.cyc = !(step inside {S_GAP, S_JAM});
        bus_req.stb = bus_req.cyc;
    end

    assign xfer_done = bus_req.stb && bus_ack;
    assign jam       = (step == S_JAM);

    // step after the current transfer and what it does to pc
    always_comb begin
        next_step   = S_FETCH;
        final_ack   = 1'b0;
        pc_cmd      = '0;
        pc_cmd.data = bus_dat;
        case (step)
            S_VEC_LO: begin
                pc_cmd.load_lo = xfer_done;
                next_step      = S_VEC_HI;
            end
            S_VEC_HI:  pc_cmd.load_hi = xfer_done;
            S_FETCH: begin
                pc_cmd.inc = xfer_done;
                if (dec.op_class == OP_ILLEGAL) begin
                    next_step = S_JAM;
                end else if (dec.op_class inside {OP_TRANSFER, OP_INCDEC, OP_FLAG}) begin
                    final_ack = xfer_done;
                end else begin
                    next_step = S_OPER;
                end
            end
            S_OPER: begin
                pc_cmd.oa_load = xfer_done;
                pc_cmd.branch  = xfer_done && (dec.op_class == OP_BRANCH) && br_taken;
                pc_cmd.inc     = xfer_done && !pc_cmd.branch;
                if (dec.op_class == OP_JMP) begin
                    next_step = S_OPER_HI;
                end else if (dec.op_class inside {OP_ZPG_ALU, OP_ZPG_LOAD, OP_ZPG_STORE}) begin
                    next_step = S_MEM;
                end else begin
                    final_ack = xfer_done;
                end
            end
            S_OPER_HI: pc_cmd.jump = xfer_done;
            S_MEM:     final_ack = xfer_done;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            step   <= S_GAP;
            resume <= S_VEC_LO;
        end else if (step == S_GAP) begin
            step <= resume;
        end else if (xfer_done) begin
            resume <= next_step;
            step   <= (next_step == S_JAM) ? S_JAM : S_GAP;
        end
    end

    always_ff @(posedge clk) begin
        if (step == S_FETCH && xfer_done) begin
            ir <= bus_dat;
        end
    end

    // register file and status written on the last ack of an instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            a_reg <= '0;
            x_reg <= '0;
            y_reg <= '0;
            p     <= '0;
        end else if (final_ack) begin
            if (wr_dst) begin
                case (dec.dst_reg)
                    REG_X:   x_reg <= alu_out.res;
                    REG_Y:   y_reg <= alu_out.res;
                    default: a_reg <= alu_out.res;
                endcase
            end
            if (upd_nz) begin
                p.n <= alu_out.flags.n;
                p.z <= alu_out.flags.z;
            end
            if (is_alu && (dec.alu_op inside {ALU_ADC, ALU_SBC, ALU_CMP})) begin
                p.c <= alu_out.flags.c;
            end
            if (is_alu && (dec.alu_op inside {ALU_ADC, ALU_SBC})) begin
                p.v <= alu_out.flags.v;
            end
            if (dec.set_c) begin
                p.c <= 1'b1;
            end
            if (dec.clr_c) begin
                p.c <= 1'b0;
            end
            if (dec.clr_v) begin
                p.v <= 1'b0;
            end
        end
    end

    // slave wait states must not disturb the request
    a_req_hold: assert property (@(posedge clk) disable iff (rst)
        bus_req.stb && !bus_ack |=> $stable(bus_req));

    a_jam_sticky: assert property (@(posedge clk) disable iff (rst)
        jam |=> jam);

endmodule

// File: verilog/pc_unit.sv
`timescale 1ns/1ps

module pc_unit
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  pc_cmd_t pc_cmd,
    output addr_t   pc,
    output byte_t   oa
);

    addr_t offset;

    assign offset = {{8{pc_cmd.data[7]}}, pc_cmd.data};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            if (pc_cmd.inc) begin
                pc <= pc + 16'd1;
            end else if (pc_cmd.jump) begin
                pc <= {pc_cmd.data, oa};
            end else if (pc_cmd.branch) begin
                // pc sits on the offset byte, so the base is one past it
                pc <= pc + 16'd1 + offset;
            end
            if (pc_cmd.load_lo) begin
                pc[7:0] <= pc_cmd.data;
            end
            if (pc_cmd.load_hi) begin
                pc[15:8] <= pc_cmd.data;
            end
        end
    end

    // operand byte, low half of a jump target or zero-page address
    always_ff @(posedge clk) begin
        if (pc_cmd.oa_load) begin
            oa <= pc_cmd.data;
        end
    end

    a_one_pc_move: assert property (@(posedge clk) disable iff (rst)
        $onehot0({pc_cmd.inc, pc_cmd.jump, pc_cmd.branch}));

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu
    import cpu_pkg::*;
(
    input  alu_in_t  alu_in,
    output alu_out_t alu_out
);

    byte_t      b_eff;
    logic       c_eff;
    logic [8:0] sum;
    byte_t      res;

    always_comb begin
        // subtract is add of the complement
        b_eff = (alu_in.op inside {ALU_SBC, ALU_CMP}) ? ~alu_in.b : alu_in.b;
        c_eff = (alu_in.op == ALU_CMP) ? 1'b1 : alu_in.ci;
        sum   = {1'b0, alu_in.a} + {1'b0, b_eff} + {8'd0, c_eff};

        case (alu_in.op)
            ALU_ADC, ALU_SBC, ALU_CMP: res = sum[7:0];
            ALU_AND: res = alu_in.a & alu_in.b;
            ALU_ORA: res = alu_in.a | alu_in.b;
            ALU_EOR: res = alu_in.a ^ alu_in.b;
            ALU_INC: res = alu_in.a + 8'd1;
            ALU_DEC: res = alu_in.a - 8'd1;
            default: res = alu_in.b;
        endcase

        alu_out.res     = res;
        alu_out.flags.n = res[7];
        alu_out.flags.z = (res == '0);
        // signed overflow: operands agree in sign, sum does not
        alu_out.flags.v = (alu_in.a[7] == b_eff[7]) && (sum[7] != alu_in.a[7]);
        alu_out.flags.c = sum[8];
    end

endmodule

// File: verilog/op_decode.sv
`timescale 1ns/1ps

module op_decode
    import cpu_pkg::*;
(
    input  byte_t    opcode,
    output decoded_t dec
);

    // register named by the low two opcode bits of loads and stores
    function automatic reg_sel_e cc_reg(input logic [1:0] cc);
        case (cc)
            2'b10:   return REG_X;
            2'b00:   return REG_Y;
            default: return REG_A;
        endcase
    endfunction

    always_comb begin
        dec          = '0;
        dec.alu_op   = ALU_PASS;
        dec.src_reg  = cc_reg(opcode[1:0]);
        dec.dst_reg  = cc_reg(opcode[1:0]);
        dec.br_flag  = opcode[7:6];
        dec.br_sense = opcode[5];

        case (opcode)
            8'h09, 8'h29, 8'h49, 8'h69, 8'hc9, 8'he9: dec.op_class = OP_IMM_ALU;
            8'h05, 8'h25, 8'h45, 8'h65, 8'hc5, 8'he5: dec.op_class = OP_ZPG_ALU;
            8'ha9, 8'ha2, 8'ha0:                      dec.op_class = OP_IMM_LOAD;
            8'ha5, 8'ha6, 8'ha4:                      dec.op_class = OP_ZPG_LOAD;
            8'h85, 8'h86, 8'h84:                      dec.op_class = OP_ZPG_STORE;
            8'haa, 8'h8a, 8'ha8, 8'h98:               dec.op_class = OP_TRANSFER;
            8'he8, 8'hc8, 8'hca, 8'h88:               dec.op_class = OP_INCDEC;
            8'h18, 8'h38, 8'hb8, 8'hea:               dec.op_class = OP_FLAG;
            8'h10, 8'h30, 8'h50, 8'h70,
            8'h90, 8'hb0, 8'hd0, 8'hf0:               dec.op_class = OP_BRANCH;
            8'h4c:                                    dec.op_class = OP_JMP;
            default:                                  dec.op_class = OP_ILLEGAL;
        endcase

        // group one: aaa field picks the operation
        if (dec.op_class inside {OP_IMM_ALU, OP_ZPG_ALU}) begin
            case (opcode[7:5])
                3'b000:  dec.alu_op = ALU_ORA;
                3'b001:  dec.alu_op = ALU_AND;
                3'b010:  dec.alu_op = ALU_EOR;
                3'b011:  dec.alu_op = ALU_ADC;
                3'b110:  dec.alu_op = ALU_CMP;
                default: dec.alu_op = ALU_SBC;
            endcase
        end

        // TAx copies out of A, TxA copies into A
        if (dec.op_class == OP_TRANSFER) begin
            if (opcode[5]) begin
                dec.src_reg = REG_A;
            end else begin
                dec.dst_reg = REG_A;
            end
        end

        case (opcode)
            8'he8: begin
                dec.alu_op  = ALU_INC;
                dec.src_reg = REG_X;
                dec.dst_reg = REG_X;
            end
            8'hc8: begin
                dec.alu_op  = ALU_INC;
                dec.src_reg = REG_Y;
                dec.dst_reg = REG_Y;
            end
            8'hca: begin
                dec.alu_op  = ALU_DEC;
                dec.src_reg = REG_X;
                dec.dst_reg = REG_X;
            end
            8'h88: begin
                dec.alu_op  = ALU_DEC;
                dec.src_reg = REG_Y;
                dec.dst_reg = REG_Y;
            end
            8'h18:   dec.clr_c = 1'b1;
            8'h38:   dec.set_c = 1'b1;
            8'hb8:   dec.clr_v = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: verilog/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] byte_t;
    typedef logic [`CPU_ADDR_W-1:0] addr_t;

    // wishbone classic master request
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        byte_t dat;
    } wb_req_t;

    typedef enum logic [3:0] {
        ALU_ADC  = 4'd0,
        ALU_SBC  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_ORA  = 4'd3,
        ALU_EOR  = 4'd4,
        ALU_CMP  = 4'd5,
        ALU_INC  = 4'd6,
        ALU_DEC  = 4'd7,
        ALU_PASS = 4'd8
    } alu_op_e;

    typedef enum logic [3:0] {
        OP_IMM_ALU   = 4'd0,
        OP_ZPG_ALU   = 4'd1,
        OP_IMM_LOAD  = 4'd2,
        OP_ZPG_LOAD  = 4'd3,
        OP_ZPG_STORE = 4'd4,
        OP_TRANSFER  = 4'd5,
        OP_INCDEC    = 4'd6,
        OP_FLAG      = 4'd7,
        OP_BRANCH    = 4'd8,
        OP_JMP       = 4'd9,
        OP_ILLEGAL   = 4'd10
    } op_class_e;

    typedef enum logic [1:0] {
        REG_A = 2'd0,
        REG_X = 2'd1,
        REG_Y = 2'd2
    } reg_sel_e;

    typedef struct packed {
        op_class_e  op_class;
        alu_op_e    alu_op;
        reg_sel_e   src_reg;
        reg_sel_e   dst_reg;
        logic [1:0] br_flag;    // 0 n, 1 v, 2 c, 3 z
        logic       br_sense;
        logic       set_c;
        logic       clr_c;
        logic       clr_v;
    } decoded_t;

    typedef struct packed {
        logic n;
        logic v;
        logic z;
        logic c;
    } flags_t;

    typedef struct packed {
        alu_op_e op;
        byte_t   a;
        byte_t   b;
        logic    ci;
    } alu_in_t;

    typedef struct packed {
        byte_t  res;
        flags_t flags;
    } alu_out_t;

    typedef struct packed {
        logic  inc;
        logic  load_lo;
        logic  load_hi;
        logic  jump;
        logic  branch;
        logic  oa_load;
        byte_t data;
    } pc_cmd_t;

endpackage

// File: verilog/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// low byte of the reset vector, high byte follows
`define CPU_RST_VECTOR 16'hfffc

`endif
